// File: source/dcache_ctrl_defines.svh
// ==================================================
// Widths and counts for the data-cache miss controller
// The line must be exactly DC_BEATS bus words wide
// ==================================================
`ifndef DCACHE_CTRL_DEFINES_SVH
`define DCACHE_CTRL_DEFINES_SVH

// Address and data widths
`define DC_ADDR_W 32
`define DC_BUS_W 128
`define DC_LINE_W 512

// Line layout on the bus
`define DC_BEATS 4
`define DC_BEAT_BITS 2
`define DC_OFS_BITS 4
`define DC_SEL_W 64

// Pause after a bus retry
`define DC_BACKOFF_WAIT 6
`define DC_LFSR_W 17

`endif

// File: source/dcache_bus_pkg.sv
// ==================================================
// Bus-side types of the miss controller
// Only three cache types are supported
// ==================================================
`include "dcache_ctrl_defines.svh"

package dcache_bus_pkg;

	// Memory attribute of a request
	typedef enum logic [1:0] {
		CT_NON_CACHEABLE = 2'd0,
		CT_WRITE_THROUGH = 2'd1,
		CT_WRITE_BACK    = 2'd2
	} cache_type_e;

	// Field view of a byte address
	typedef struct packed {
		logic [`DC_ADDR_W-`DC_BEAT_BITS-`DC_OFS_BITS-1:0] line;
		logic [`DC_BEAT_BITS-1:0] beat;
		logic [`DC_OFS_BITS-1:0] offset;
	} bus_addr_fld_t;

	// ==================================================
	// Bus address
	// ==================================================
	// The same word is read either flat or as line, beat and offset
	typedef union packed {
		logic [`DC_ADDR_W-1:0] word;
		bus_addr_fld_t fld;
	} bus_addr_u;

endpackage

// File: source/dcache_line_pkg.sv
// ==================================================
// Line-side types of the miss controller
// ==================================================
`include "dcache_ctrl_defines.svh"

package dcache_line_pkg;

	// One full cache line and its byte selects
	typedef logic [`DC_LINE_W-1:0] line_t;
	typedef logic [`DC_SEL_W-1:0] line_sel_t;

	// Sequencer states
	typedef enum logic [2:0] {
		IDLE    = 3'd0,
		DUMP    = 3'd1,
		LOAD    = 3'd2,
		STRIP   = 3'd3,
		BACKOFF = 3'd4,
		FINISH  = 3'd5
	} seq_state_e;

endpackage

// File: source/dcache_backoff.sv
// ==================================================
// Retry back-off, a fixed wait then an LFSR match
// expired_o holds until the next start_i
// ==================================================
`timescale 1ns/1ps
`include "dcache_ctrl_defines.svh"

module dcache_backoff (
	input  logic clk_i,
	input  logic rst_i,
	input  logic start_i,
	output logic expired_o
);
	localparam int CNT_W = $clog2(`DC_BACKOFF_WAIT + 1);

	logic [`DC_LFSR_W-1:0] lfsr_r;
	logic [CNT_W-1:0] wait_cnt_r;
	logic active_r;

	// Free running Fibonacci LFSR, taps for x^17 + x^14 + 1
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			lfsr_r <= `DC_LFSR_W'd1;
		end else begin
			lfsr_r <= {lfsr_r[`DC_LFSR_W-2:0], lfsr_r[`DC_LFSR_W-1] ^ lfsr_r[13]};
		end
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			wait_cnt_r <= '0;
			active_r <= 1'b0;
			expired_o <= 1'b0;
		end else if (start_i) begin
			wait_cnt_r <= '0;
			active_r <= 1'b1;
			expired_o <= 1'b0;
		end else if (active_r) begin
			if (wait_cnt_r != CNT_W'(`DC_BACKOFF_WAIT)) begin
				wait_cnt_r <= wait_cnt_r + 1'b1;
			end else if (lfsr_r[3:1] == 3'b111) begin
				active_r <= 1'b0;
				expired_o <= 1'b1;
			end
		end
	end
endmodule

// File: source/dcache_req_seq.sv
// ==================================================
// Request sequencer, one request in flight at a time
// Request and victim inputs must hold until done_o
// ==================================================
`timescale 1ns/1ps
`include "dcache_ctrl_defines.svh"

module dcache_req_seq import dcache_line_pkg::*, dcache_bus_pkg::*; (
	input  logic clk_i,
	input  logic rst_i,
	input  logic req_i,
	input  bus_addr_u req_adr_i,
	input  logic req_we_i,
	input  cache_type_e req_cache_i,
	input  logic dce_i,
	input  logic hit_i,
	input  logic modified_i,
	input  bus_addr_u victim_adr_i,
	input  line_t victim_dat_i,
	input  line_sel_t wr_sel_i,
	input  line_t wr_dat_i,
	input  logic bus_ack_i,
	input  logic bus_rty_i,
	input  logic expired_i,
	output logic busy_o,
	output logic done_o,
	output logic cache_wr_o,
	output logic accept_o,
	output logic beat_ack_o,
	output logic [`DC_BEAT_BITS-1:0] beat_o,
	output logic retry_o,
	output logic bus_cyc_o,
	output logic bus_we_o,
	output bus_addr_u bus_adr_o,
	output logic [`DC_BUS_W-1:0] bus_dat_o
);
	localparam int BEAT_SEL = `DC_BUS_W / 8;

	seq_state_e state_r, ret_state_r, act_state;
	logic [`DC_BEAT_BITS-1:0] beat_r;
	logic cyc_r, alloc_r;
	logic non_cacheable, wt_write, strip_hit, last_beat;

	assign non_cacheable = (req_cache_i == CT_NON_CACHEABLE) || !dce_i;
	assign wt_write = (req_cache_i == CT_WRITE_THROUGH) && req_we_i;
	assign strip_hit = |wr_sel_i[beat_r*BEAT_SEL +: BEAT_SEL];
	assign last_beat = (beat_r == `DC_BEAT_BITS'(`DC_BEATS - 1));

	// While backing off the bus fields follow the phase that will resume
	assign act_state = (state_r == BACKOFF) ? ret_state_r : state_r;

	assign busy_o = (state_r == DUMP) || (state_r == LOAD) || (state_r == STRIP) ||
		(state_r == BACKOFF);
	assign done_o = (state_r == FINISH);
	assign cache_wr_o = (state_r == FINISH) && alloc_r;
	assign accept_o = req_i && ((state_r == IDLE) || (state_r == FINISH));
	assign beat_o = beat_r;
	assign bus_cyc_o = cyc_r;
	assign bus_we_o = (act_state == DUMP) || ((act_state == STRIP) && req_we_i);
	assign beat_ack_o = cyc_r && bus_ack_i && !bus_we_o;
	assign retry_o = cyc_r && bus_rty_i && !bus_ack_i;

	always_comb begin
		if (act_state == DUMP) begin
			bus_adr_o.word = {victim_adr_i.fld.line, beat_r, {`DC_OFS_BITS{1'b0}}};
			bus_dat_o = victim_dat_i[beat_r*`DC_BUS_W +: `DC_BUS_W];
		end else begin
			bus_adr_o.word = {req_adr_i.fld.line, beat_r, {`DC_OFS_BITS{1'b0}}};
			bus_dat_o = bus_we_o ? wr_dat_i[beat_r*`DC_BUS_W +: `DC_BUS_W] : '0;
		end
	end

	// ==================================================
	// Sequencer FSM
	// ==================================================
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			state_r <= IDLE;
			ret_state_r <= IDLE;
			beat_r <= '0;
			cyc_r <= 1'b0;
			alloc_r <= 1'b0;
		end else begin
			case (state_r)
				IDLE, FINISH: begin
					if (accept_o) begin
						beat_r <= '0;
						alloc_r <= 1'b0;
						if (non_cacheable || (hit_i && wt_write)) begin
							state_r <= STRIP;
						end else if (hit_i) begin
							state_r <= FINISH;
						end else begin
							// Allocating miss, write back a dirty victim first
							alloc_r <= 1'b1;
							state_r <= modified_i ? DUMP : LOAD;
						end
					end else begin
						state_r <= IDLE;
					end
				end
				DUMP, LOAD, STRIP: begin
					if (!cyc_r) begin
						// Strip beats without any selected byte are skipped
						if ((state_r != STRIP) || strip_hit) begin
							cyc_r <= 1'b1;
						end else if (last_beat) begin
							state_r <= FINISH;
						end else begin
							beat_r <= beat_r + 1'b1;
						end
					end else if (bus_ack_i) begin
						cyc_r <= 1'b0;
						beat_r <= beat_r + 1'b1;
						if (last_beat) begin
							state_r <= (state_r == DUMP) ? LOAD : FINISH;
						end
					end else if (bus_rty_i) begin
						cyc_r <= 1'b0;
						ret_state_r <= state_r;
						state_r <= BACKOFF;
					end
				end
				BACKOFF: begin
					if (expired_i) begin
						state_r <= ret_state_r;
					end
				end
				default: state_r <= IDLE;
			endcase
		end
	end
endmodule

// File: source/dcache_line_assembler.sv
// ==================================================
// Collects read beats into a line and overlays the
// CPU write bytes, unread beats stay zero
// ==================================================
`timescale 1ns/1ps
`include "dcache_ctrl_defines.svh"

module dcache_line_assembler import dcache_line_pkg::*; (
	input  logic clk_i,
	input  logic rst_i,
	input  logic accept_i,
	input  logic req_we_i,
	input  line_sel_t req_sel_i,
	input  line_t req_dat_i,
	input  logic beat_ack_i,
	input  logic [`DC_BEAT_BITS-1:0] beat_i,
	input  logic [`DC_BUS_W-1:0] bus_dat_i,
	output line_t line_o,
	output line_sel_t wr_sel_o,
	output line_t wr_dat_o
);
	logic we_r;
	line_sel_t sel_r;
	line_t dat_r;
	line_t buf_r;

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			we_r <= 1'b0;
		end else if (accept_i) begin
			we_r <= req_we_i;
		end
	end

	// Request capture and beat collection
	always_ff @(posedge clk_i) begin
		if (accept_i) begin
			sel_r <= req_sel_i;
			dat_r <= req_dat_i;
			buf_r <= '0;
		end else if (beat_ack_i) begin
			buf_r[beat_i*`DC_BUS_W +: `DC_BUS_W] <= bus_dat_i;
		end
	end

	// ==================================================
	// Write merge
	// ==================================================
	always_comb begin
		line_o = buf_r;
		if (we_r) begin
			for (int i = 0; i < `DC_SEL_W; i++) begin
				if (sel_r[i]) begin
					line_o[i*8 +: 8] = dat_r[i*8 +: 8];
				end
			end
		end
	end

	// Strip writes take their beats straight from the captured request
	assign wr_sel_o = sel_r;
	assign wr_dat_o = dat_r;
endmodule

// File: source/dcache_ctrl.sv
// ==================================================
// Data-cache miss controller, 512-bit line over a
// 128-bit bus, one request in flight
// ==================================================
`timescale 1ns/1ps
`include "dcache_ctrl_defines.svh"

module dcache_ctrl import dcache_line_pkg::*, dcache_bus_pkg::*; (
	input  logic clk_i,
	input  logic rst_i,
	input  logic req_i,
	input  bus_addr_u req_adr_i,
	input  logic req_we_i,
	input  line_sel_t req_sel_i,
	input  line_t req_dat_i,
	input  cache_type_e req_cache_i,
	input  logic dce_i,
	input  logic hit_i,
	input  logic modified_i,
	input  bus_addr_u victim_adr_i,
	input  line_t victim_dat_i,
	output logic busy_o,
	output logic done_o,
	output logic cache_wr_o,
	output line_t line_o,
	output logic bus_cyc_o,
	output logic bus_we_o,
	output bus_addr_u bus_adr_o,
	output logic [`DC_BUS_W-1:0] bus_dat_o,
	input  logic bus_ack_i,
	input  logic bus_rty_i,
	input  logic [`DC_BUS_W-1:0] bus_dat_i
);
	logic accept, beat_ack, retry, expired;
	logic [`DC_BEAT_BITS-1:0] beat;
	line_sel_t wr_sel;
	line_t wr_dat;

	dcache_req_seq i_req_seq (
		.clk_i, .rst_i, .req_i, .req_adr_i, .req_we_i, .req_cache_i,
		.dce_i, .hit_i, .modified_i, .victim_adr_i, .victim_dat_i,
		.wr_sel_i(wr_sel), .wr_dat_i(wr_dat), .bus_ack_i, .bus_rty_i,
		.expired_i(expired), .busy_o, .done_o, .cache_wr_o,
		.accept_o(accept), .beat_ack_o(beat_ack), .beat_o(beat), .retry_o(retry),
		.bus_cyc_o, .bus_we_o, .bus_adr_o, .bus_dat_o
	);

	dcache_line_assembler i_line_assembler (
		.clk_i, .rst_i, .accept_i(accept), .req_we_i, .req_sel_i, .req_dat_i,
		.beat_ack_i(beat_ack), .beat_i(beat), .bus_dat_i,
		.line_o, .wr_sel_o(wr_sel), .wr_dat_o(wr_dat)
	);

	dcache_backoff i_backoff (
		.clk_i, .rst_i, .start_i(retry), .expired_o(expired)
	);
endmodule

// File: dv/dcache_ctrl_properties.sv
// ==================================================
// Bus and completion rules, bound to dcache_ctrl
// ==================================================
`timescale 1ns/1ps
`include "dcache_ctrl_defines.svh"

module dcache_ctrl_properties (
	input logic clk_i,
	input logic rst_i,
	input logic busy_i,
	input logic done_i,
	input logic cache_wr_i,
	input logic bus_cyc_i,
	input logic bus_we_i,
	input logic [`DC_ADDR_W-1:0] bus_adr_i,
	input logic [`DC_BUS_W-1:0] bus_wdat_i,
	input logic bus_ack_i,
	input logic bus_rty_i
);
	// Number of failed assertions
	int fail_cnt = 0;

	// A pending beat keeps its fields until the memory answers
	beat_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
		bus_cyc_i && !bus_ack_i && !bus_rty_i |=>
		bus_cyc_i && $stable(bus_adr_i) && $stable(bus_wdat_i) && $stable(bus_we_i))
		else begin
			fail_cnt++;
			$error("bus fields changed while a beat was pending");
		end

	cache_wr_done_a: assert property (@(posedge clk_i) disable iff (rst_i)
		cache_wr_i |-> done_i)
		else begin
			fail_cnt++;
			$error("cache write pulse without done");
		end

	// Everything is quiet in the first cycle after reset
	reset_quiet_a: assert property (@(posedge clk_i)
		$fell(rst_i) |-> !busy_i && !bus_cyc_i && !done_i && !cache_wr_i)
		else begin
			fail_cnt++;
			$error("controller active right after reset");
		end

	cyc_busy_a: assert property (@(posedge clk_i) disable iff (rst_i)
		bus_cyc_i |-> busy_i)
		else begin
			fail_cnt++;
			$error("bus cycle issued while not busy");
		end
endmodule

// File: dv/tb_dcache_ctrl.sv
// ==================================================
// Directed testbench with a memory bus model
// The memory model covers byte addresses below 4 KB
// ==================================================
`timescale 1ns/1ps
`include "dcache_ctrl_defines.svh"

module tb_dcache_ctrl import dcache_line_pkg::*, dcache_bus_pkg::*; ();
	// Six tests with retries need a few hundred cycles, so this is ample
	localparam int TIMEOUT = 20000;
	localparam int MEM_WORDS = 256;

	logic clk_i = 1'b0;
	logic rst_i = 1'b1;
	logic req_i, req_we_i, dce_i, hit_i, modified_i;
	bus_addr_u req_adr_i, victim_adr_i, bus_adr_o;
	line_sel_t req_sel_i;
	line_t req_dat_i, victim_dat_i, line_o;
	cache_type_e req_cache_i;
	logic busy_o, done_o, cache_wr_o, bus_cyc_o, bus_we_o, bus_ack_i, bus_rty_i;
	logic [`DC_BUS_W-1:0] bus_dat_o, bus_dat_i;

	// Memory model state and the log of acknowledged beats
	logic [`DC_BUS_W-1:0] mem [MEM_WORDS];
	logic [`DC_ADDR_W-1:0] log_adr [$];
	logic log_we [$];
	logic retry_on, armed, rty_pend, busy_seen;
	logic [`DC_ADDR_W-1:0] rty_adr;
	logic [`DC_BUS_W-1:0] rty_dat;
	integer seed;
	int stall, rty_cnt, checks, errors;
	int cycles = 0;
	line_t got_line;
	logic got_wr;
	int got_lat;

	dcache_ctrl i_dcache_ctrl (.*);

	bind dcache_ctrl dcache_ctrl_properties i_properties (
		.clk_i, .rst_i, .busy_i(busy_o), .done_i(done_o), .cache_wr_i(cache_wr_o),
		.bus_cyc_i(bus_cyc_o), .bus_we_i(bus_we_o), .bus_adr_i(bus_adr_o),
		.bus_wdat_i(bus_dat_o), .bus_ack_i, .bus_rty_i
	);

	always #50 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("timeout: the run did not end within %0d cycles", TIMEOUT);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic compare_values(input string what, input logic [`DC_LINE_W-1:0] got,
			input logic [`DC_LINE_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic line_t rand_line();
		line_t l;
		for (int i = 0; i < `DC_LINE_W / 32; i++) begin
			l[i*32 +: 32] = $random(seed);
		end
		return l;
	endfunction

	function automatic line_t mem_line(input logic [`DC_ADDR_W-1:0] adr);
		line_t l;
		for (int b = 0; b < `DC_BEATS; b++) begin
			l[b*`DC_BUS_W +: `DC_BUS_W] = mem[adr[11:6] * 4 + b];
		end
		return l;
	endfunction

	// ==================================================
	// Memory bus model
	// ==================================================
	// Answers a beat after up to two stall cycles, with random retries when enabled
	always @(negedge clk_i) begin
		if (busy_o) begin
			busy_seen = 1'b1;
		end
		if (rst_i || bus_ack_i || bus_rty_i || !bus_cyc_o) begin
			bus_ack_i = 1'b0;
			bus_rty_i = 1'b0;
			armed = 1'b0;
		end else begin
			if (!armed) begin
				armed = 1'b1;
				stall = $unsigned($random(seed)) % 3;
				if (rty_pend) begin
					rty_pend = 1'b0;
					compare_values("reissued address", bus_adr_o.word, rty_adr);
					compare_values("reissued data", bus_dat_o, rty_dat);
				end
			end
			if (stall > 0) begin
				stall--;
			end else if (retry_on && ($random(seed) & 1)) begin
				bus_rty_i = 1'b1;
				rty_cnt++;
				rty_pend = 1'b1;
				rty_adr = bus_adr_o.word;
				rty_dat = bus_dat_o;
			end else begin
				bus_ack_i = 1'b1;
				log_adr.push_back(bus_adr_o.word);
				log_we.push_back(bus_we_o);
				if (bus_we_o) begin
					mem[bus_adr_o.word[11:4]] = bus_dat_o;
				end else begin
					bus_dat_i = mem[bus_adr_o.word[11:4]];
				end
			end
		end
	end

	// Pulses req_i and waits for done_o, counting cycles from the request
	task automatic start_req(input logic [`DC_ADDR_W-1:0] adr, input cache_type_e cache,
			input logic we, input logic hit, input logic dirty);
		req_adr_i = adr;
		req_cache_i = cache;
		req_we_i = we;
		hit_i = hit;
		modified_i = dirty;
		log_adr.delete();
		log_we.delete();
		busy_seen = 1'b0;
		req_i = 1'b1;
		@(negedge clk_i);
		req_i = 1'b0;
		got_lat = 1;
		while (done_o !== 1'b1) begin
			@(negedge clk_i);
			got_lat++;
		end
		got_line = line_o;
		got_wr = cache_wr_o;
	endtask

	task automatic test_read_hits();
		cache_type_e types [2] = '{CT_WRITE_BACK, CT_WRITE_THROUGH};
		foreach (types[i]) begin
			start_req(32'h0000_0100 + 32'h40 * i, types[i], 1'b0, 1'b1, 1'b0);
			compare_values("hit latency in cycles", got_lat, 1);
			compare_values("hit bus beats", log_adr.size(), 0);
			compare_values("busy during hit", busy_seen, 1'b0);
			compare_values("hit cache write", got_wr, 1'b0);
		end
	endtask

	task automatic test_line_miss(input logic [`DC_ADDR_W-1:0] adr,
			input logic [`DC_ADDR_W-1:0] vadr, input logic dirty, input logic we);
		line_t exp_line;
		int n;
		victim_adr_i = vadr;
		victim_dat_i = rand_line();
		req_sel_i = {$random(seed), $random(seed)};
		req_dat_i = rand_line();
		exp_line = mem_line(adr);
		// Written bytes land on top of the loaded line
		for (int i = 0; i < `DC_SEL_W; i++) begin
			if (we && req_sel_i[i]) begin
				exp_line[i*8 +: 8] = req_dat_i[i*8 +: 8];
			end
		end
		start_req(adr, CT_WRITE_BACK, we, 1'b0, dirty);
		n = dirty ? `DC_BEATS : 0;
		compare_values("miss bus beats", log_adr.size(), n + `DC_BEATS);
		for (int b = 0; b < `DC_BEATS; b++) begin
			if (dirty) begin
				compare_values("dump address", log_adr[b], {vadr[31:6], 6'd0} + 16 * b);
				compare_values("dump direction", log_we[b], 1'b1);
			end
			compare_values("load address", log_adr[n + b], {adr[31:6], 6'd0} + 16 * b);
			compare_values("load direction", log_we[n + b], 1'b0);
		end
		if (dirty) begin
			compare_values("victim line in memory", mem_line(vadr), victim_dat_i);
		end
		compare_values("loaded line", got_line, exp_line);
		compare_values("miss cache write", got_wr, 1'b1);
	endtask

	task automatic test_strip(input logic [`DC_ADDR_W-1:0] adr, input cache_type_e cache,
			input logic hit, input logic we, input line_sel_t sel);
		line_t old_line, exp_line;
		int n;
		req_sel_i = sel;
		req_dat_i = rand_line();
		old_line = mem_line(adr);
		exp_line = we ? old_line : '0;
		start_req(adr, cache, we, hit, 1'b0);
		n = 0;
		for (int b = 0; b < `DC_BEATS; b++) begin
			// Only beats with a selected byte go on the bus
			if (sel[b*16 +: 16] != 16'h0) begin
				compare_values("strip address", log_adr[n], {adr[31:6], 6'd0} + 16 * b);
				compare_values("strip direction", log_we[n], we);
				exp_line[b*`DC_BUS_W +: `DC_BUS_W] = we ?
					req_dat_i[b*`DC_BUS_W +: `DC_BUS_W] : old_line[b*`DC_BUS_W +: `DC_BUS_W];
				n++;
			end
		end
		compare_values("strip bus beats", log_adr.size(), n);
		if (we) begin
			compare_values("memory after strip write", mem_line(adr), exp_line);
		end else begin
			compare_values("strip read line", got_line, exp_line);
		end
		compare_values("strip cache write", got_wr, 1'b0);
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		seed = 32'h2624_cd06;
		req_i = 1'b0;
		req_adr_i = '0;
		req_we_i = 1'b0;
		req_sel_i = '0;
		req_dat_i = '0;
		req_cache_i = CT_WRITE_BACK;
		dce_i = 1'b1;
		hit_i = 1'b0;
		modified_i = 1'b0;
		victim_adr_i = '0;
		victim_dat_i = '0;
		bus_ack_i = 1'b0;
		bus_rty_i = 1'b0;
		bus_dat_i = '0;
		retry_on = 1'b0;
		armed = 1'b0;
		rty_pend = 1'b0;
		rty_cnt = 0;
		checks = 0;
		errors = 0;
		// Each word carries its own index, so no two words match
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = {4{32'hC0DE_0000 ^ 32'(i * 32'h0101_0003)}};
		end
		repeat (3) @(negedge clk_i);
		rst_i = 1'b0;
		@(negedge clk_i);
		test_read_hits();
		test_line_miss(32'h0000_0120, 32'h0000_0000, 1'b0, 1'b0);
		test_line_miss(32'h0000_0234, 32'h0000_0380, 1'b1, 1'b1);
		test_strip(32'h0000_0440, CT_NON_CACHEABLE, 1'b0, 1'b1, 64'h0000_00F0_0000_0F00);
		test_strip(32'h0000_0500, CT_NON_CACHEABLE, 1'b0, 1'b0, 64'h0180_0000_3C00_0000);
		test_strip(32'h0000_0600, CT_WRITE_THROUGH, 1'b1, 1'b1, 64'h0000_0001_FF00_0000);
		retry_on = 1'b1;
		test_line_miss(32'h0000_0120, 32'h0000_0000, 1'b0, 1'b0);
		test_strip(32'h0000_0440, CT_NON_CACHEABLE, 1'b0, 1'b1, 64'h0000_00F0_0000_0F00);
		test_strip(32'h0000_0500, CT_NON_CACHEABLE, 1'b0, 1'b0, 64'h0180_0000_3C00_0000);
		compare_values("retries injected", rty_cnt > 0, 1'b1);
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			i_dcache_ctrl.i_properties.fail_cnt);
		if ((errors == 0) && (i_dcache_ctrl.i_properties.fail_cnt == 0)) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end
endmodule

// File: dcache_ctrl.f
+incdir+source
source/dcache_bus_pkg.sv
source/dcache_line_pkg.sv
source/dcache_backoff.sv
source/dcache_req_seq.sv
source/dcache_line_assembler.sv
source/dcache_ctrl.sv
dv/dcache_ctrl_properties.sv
dv/tb_dcache_ctrl.sv

// File: Bender.yml
package:
  name: dcache_ctrl

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/dcache_bus_pkg.sv
      - source/dcache_line_pkg.sv
      - source/dcache_backoff.sv
      - source/dcache_req_seq.sv
      - source/dcache_line_assembler.sv
      - source/dcache_ctrl.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/dcache_ctrl_properties.sv
      - dv/tb_dcache_ctrl.sv
